// File: design/conv_ctrl.sv
`include "conv_params.svh"

module conv_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  logic [`CONV_KSIZE_W-1:0] kernel_size,
	output conv_pkg::win_op_t        win_op,
	output conv_pkg::mac_ctrl_t      mac_ctrl,
	output logic                     busy,
	output logic                     done
);
	import conv_pkg::*;

	ctrl_state_t              state;
	logic [`CONV_KSIZE_W-1:0] ksize_q;
	logic [`CONV_KSIZE_W-1:0] col_cnt;
	logic [`CONV_KSIZE_W-1:0] row_cnt;
	logic [`CONV_STEP_W-1:0]  step_cnt;
	logic [`CONV_STEP_W-1:0]  kk_last;
	logic                     launch;
	logic                     last_step;

	assign launch    = (state == ST_IDLE) && start;
	assign last_step = (state == ST_RUN) && (step_cnt == kk_last);

	// window op for the step presented this cycle
	always_comb
	begin
		win_op = WIN_HOLD;
		if (launch)
			win_op = WIN_LOAD;
		else if (state == ST_RUN)
			win_op = (col_cnt == '0 && row_cnt != '0) ? WIN_ROW : WIN_SHIFT;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state    <= ST_IDLE;
			ksize_q  <= '0;
			col_cnt  <= '0;
			row_cnt  <= '0;
			step_cnt <= '0;
			kk_last  <= '0;
			mac_ctrl <= '0;
			busy     <= 1'b0;
			done     <= 1'b0;
		end
		else
		begin
			// MAC controls trail the window by one cycle
			mac_ctrl.clear   <= launch;
			mac_ctrl.en      <= launch || (state == ST_RUN);
			mac_ctrl.capture <= (state == ST_FLUSH);
			done             <= (state == ST_FLUSH);
			if (launch)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;

			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						ksize_q  <= kernel_size;
						kk_last  <= `CONV_STEP_W'(kernel_size) * `CONV_STEP_W'(kernel_size)
							- `CONV_STEP_W'(1);
						col_cnt  <= `CONV_KSIZE_W'(1);
						row_cnt  <= '0;
						step_cnt <= `CONV_STEP_W'(1);
						// a 1x1 kernel is finished after step 0
						state    <= (kernel_size == `CONV_KSIZE_W'(1)) ? ST_FLUSH : ST_RUN;
					end
				end
				ST_RUN:
				begin
					step_cnt <= step_cnt + `CONV_STEP_W'(1);
					if (col_cnt == ksize_q - `CONV_KSIZE_W'(1))
					begin
						col_cnt <= '0;
						row_cnt <= row_cnt + `CONV_KSIZE_W'(1);
					end
					else
						col_cnt <= col_cnt + `CONV_KSIZE_W'(1);
					if (last_step)
						state <= ST_FLUSH;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst) busy |-> !start);
	assert property (@(posedge clk) disable iff (!rst)
		busy |-> (ksize_q >= 1 && ksize_q <= `CONV_KERNEL_MAX));
	assert property (@(posedge clk) disable iff (!rst) done |=> !done);
	// step count and row/col counters agree on the last step
	assert property (@(posedge clk) disable iff (!rst)
		last_step |-> (row_cnt == ksize_q - 1 && col_cnt == ksize_q - 1));

endmodule

// File: design/conv_mac.sv
`include "conv_params.svh"

module conv_mac (
	input  logic                clk,
	input  logic                rst,
	input  conv_pkg::pixel_t    a,
	input  conv_pkg::pixel_t    b,
	input  conv_pkg::mac_ctrl_t ctrl,
	output conv_pkg::pixel_t    sum
);
	import conv_pkg::*;

	localparam acc_t SAT_MAX = (acc_t'(1) <<< (`CONV_DATA_W - 1)) - acc_t'(1);
	localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

	logic signed [2*`CONV_DATA_W-1:0] prod;
	acc_t                             acc;
	acc_t                             scaled;

	// full-width product
	assign prod = a * b;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			acc <= '0;
		else if (ctrl.en)
			acc <= ctrl.clear ? acc_t'(prod) : acc + acc_t'(prod);
	end

	// drop fraction bits, then clamp to 16 bits
	assign scaled = acc >>> `CONV_FRAC_BITS;

	always_comb
	begin
		if (scaled > SAT_MAX)
			sum = pixel_t'(SAT_MAX);
		else if (scaled < SAT_MIN)
			sum = pixel_t'(SAT_MIN);
		else
			sum = pixel_t'(scaled[`CONV_DATA_W-1:0]);
	end

endmodule

// File: design/conv_mac_array.sv
`include "conv_params.svh"

module conv_mac_array (
	input  logic                clk,
	input  logic                rst,
	input  conv_pkg::feat_vec_t taps,
	input  conv_pkg::pixel_t    weight,
	input  conv_pkg::mac_ctrl_t mac_ctrl,
	output conv_pkg::result_t   result
);
	import conv_pkg::*;

	pixel_t  weight_q;
	pixel_t  lane_sum [NUM_LANES];
	result_t sums;

	// weight delayed to line up with the registered taps
	always_ff @(posedge clk)
	begin
		weight_q <= weight;
	end

	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		conv_mac u_mac (
			.clk  (clk),
			.rst  (rst),
			.a    (taps.lane[i]),
			.b    (weight_q),
			.ctrl (mac_ctrl),
			.sum  (lane_sum[i])
		);
	end

	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			sums.px[i] = lane_sum[i];
		end
	end

	// result holds until the next capture
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			result <= '0;
		else if (mac_ctrl.capture)
			result <= sums;
	end

endmodule

// File: design/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// data format
////////////////////////////////////////////////////////////////////////////

// signed fixed point, 8 fractional bits
`define CONV_DATA_W      16
`define CONV_FRAC_BITS   8
`define CONV_ACC_W       40

////////////////////////////////////////////////////////////////////////////
// tile geometry
////////////////////////////////////////////////////////////////////////////

// row groups x lanes per group
`define CONV_PARA_X      3
`define CONV_PARA_Y      3
`define CONV_KERNEL_MAX  11
`define CONV_KSIZE_W     4
`define CONV_STEP_W      7

`endif

// File: design/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

	localparam int NUM_LANES = `CONV_PARA_X * `CONV_PARA_Y;

	typedef logic signed [`CONV_DATA_W-1:0] pixel_t;
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	// one pixel per lane, lane x*PARA_Y+y
	typedef struct packed {
		pixel_t [NUM_LANES-1:0] lane;
	} feat_vec_t;

	// output tile, row-major
	typedef struct packed {
		pixel_t [NUM_LANES-1:0] px;
	} result_t;

	typedef enum logic [1:0] {
		WIN_HOLD,
		WIN_LOAD,
		WIN_SHIFT,
		WIN_ROW
	} win_op_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_FLUSH
	} ctrl_state_t;

	typedef struct packed {
		logic clear;
		logic en;
		logic capture;
	} mac_ctrl_t;

endpackage

// File: design/conv_tile_top.sv
`include "conv_params.svh"

module conv_tile_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  logic [`CONV_KSIZE_W-1:0] kernel_size,
	input  conv_pkg::feat_vec_t      feat_in,
	input  conv_pkg::pixel_t         weight,
	output logic                     busy,
	output logic                     done,
	output conv_pkg::result_t        result
);
	import conv_pkg::*;

	win_op_t   win_op;
	mac_ctrl_t mac_ctrl;
	feat_vec_t taps;

	conv_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.kernel_size (kernel_size),
		.win_op      (win_op),
		.mac_ctrl    (mac_ctrl),
		.busy        (busy),
		.done        (done)
	);

	conv_window u_window (
		.clk     (clk),
		.rst     (rst),
		.win_op  (win_op),
		.feat_in (feat_in),
		.taps    (taps)
	);

	conv_mac_array u_mac_array (
		.clk      (clk),
		.rst      (rst),
		.taps     (taps),
		.weight   (weight),
		.mac_ctrl (mac_ctrl),
		.result   (result)
	);

endmodule

// File: design/conv_window.sv
`include "conv_params.svh"

module conv_window (
	input  logic                clk,
	input  logic                rst,
	input  conv_pkg::win_op_t   win_op,
	input  conv_pkg::feat_vec_t feat_in,
	output conv_pkg::feat_vec_t taps
);
	import conv_pkg::*;

	// current window row and saved leading pixels, per group
	pixel_t win_q  [`CONV_PARA_X][`CONV_PARA_Y];
	pixel_t head_q [`CONV_PARA_X][`CONV_PARA_Y];

	always_ff @(posedge clk)
	begin
		case (win_op)
			WIN_LOAD:
			begin
				for (int x = 0; x < `CONV_PARA_X; x++)
				begin
					for (int y = 0; y < `CONV_PARA_Y; y++)
					begin
						win_q[x][y]  <= feat_in.lane[x*`CONV_PARA_Y+y];
						head_q[x][y] <= feat_in.lane[x*`CONV_PARA_Y+y];
					end
				end
			end
			WIN_SHIFT:
			begin
				// one new column pixel per group, group x on lane x
				for (int x = 0; x < `CONV_PARA_X; x++)
				begin
					for (int y = 0; y < `CONV_PARA_Y - 1; y++)
					begin
						win_q[x][y] <= win_q[x][y+1];
					end
					win_q[x][`CONV_PARA_Y-1] <= feat_in.lane[x];
				end
			end
			WIN_ROW:
			begin
				// upper groups reuse the head of the group below
				for (int x = 0; x < `CONV_PARA_X - 1; x++)
				begin
					for (int y = 0; y < `CONV_PARA_Y; y++)
					begin
						win_q[x][y]  <= head_q[x+1][y];
						head_q[x][y] <= head_q[x+1][y];
					end
				end
				// bottom group reads the new row
				for (int y = 0; y < `CONV_PARA_Y; y++)
				begin
					win_q[`CONV_PARA_X-1][y]  <= feat_in.lane[y];
					head_q[`CONV_PARA_X-1][y] <= feat_in.lane[y];
				end
			end
			default:
			begin
			end
		endcase
	end

	always_comb
	begin
		for (int x = 0; x < `CONV_PARA_X; x++)
		begin
			for (int y = 0; y < `CONV_PARA_Y; y++)
			begin
				taps.lane[x*`CONV_PARA_Y+y] = win_q[x][y];
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst) !$isunknown(win_op));

endmodule

// File: dv/conv_tb_model.svh
////////////////////////////////////////////////////////////////////////////
// reference model and result compare
////////////////////////////////////////////////////////////////////////////

// expected tile from img and ker, signed fixed point with saturation
function automatic result_t ref_conv(input int k);
	result_t r;
	longint  acc;
	longint  scaled;
	longint  max_val;
	max_val = (longint'(1) << (`CONV_DATA_W - 1)) - 1;
	for (int x = 0; x < `CONV_PARA_X; x++)
	begin
		for (int y = 0; y < `CONV_PARA_Y; y++)
		begin
			acc = 0;
			for (int u = 0; u < k; u++)
				for (int v = 0; v < k; v++)
					acc += longint'(img[x+u][y+v]) * longint'(ker[u][v]);
			scaled = acc >>> `CONV_FRAC_BITS;
			if (scaled > max_val)
				scaled = max_val;
			else if (scaled < -max_val - 1)
				scaled = -max_val - 1;
			r.px[x*`CONV_PARA_Y+y] = pixel_t'(scaled);
		end
	end
	return r;
endfunction

task automatic check_result(input result_t got, input result_t expected);
	for (int i = 0; i < NUM_LANES; i++)
	begin
		if (got.px[i] !== expected.px[i])
		begin
			$display("MISMATCH at %0t: lane %0d got %0d expected %0d",
				$time, i, got.px[i], expected.px[i]);
			stop_with_failure("output tile differs from the reference model");
		end
	end
endtask

// File: dv/conv_tb.sv
`include "conv_params.svh"

module conv_tb;
	import conv_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int IMG_H      = `CONV_PARA_X + `CONV_KERNEL_MAX - 1;
	localparam int IMG_W      = `CONV_PARA_Y + `CONV_KERNEL_MAX - 1;
	localparam int NUM_TESTS  = 8;

	logic                     clk;
	logic                     rst;
	logic                     start;
	logic [`CONV_KSIZE_W-1:0] kernel_size;
	feat_vec_t                feat_in;
	pixel_t                   weight;
	logic                     busy;
	logic                     done;
	result_t                  result;

	// kernel side and data mode per run
	// modes 1 and 2 give large positive and negative pixels
	int        test_k    [NUM_TESTS] = '{1, 3, 5, 11, 11, 3, 7, 2};
	int        test_mode [NUM_TESTS] = '{0, 0, 0, 1, 2, 0, 0, 0};
	pixel_t    img [IMG_H][IMG_W];
	pixel_t    ker [`CONV_KERNEL_MAX][`CONV_KERNEL_MAX];
	bit [31:0] lcg_state = 32'd37335;
	int        cyc = 0;
	result_t   exp_q [$];
	int        due_q [$];
	bit        pending = 1'b0;
	bit        checking = 1'b0;
	result_t   held = '0;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	`include "conv_tb_model.svh"

	conv_tile_top DUT (.*);

	// LCG taking its upper bits
	function automatic pixel_t rand_pixel(input int mode);
		bit [31:0] r;
		r = lcg_state * 32'd1103515245 + 32'd12345;
		lcg_state = r;
		case (mode)
			1: return pixel_t'({2'b01, r[29:16]});
			2: return pixel_t'({2'b10, r[29:16]});
			default: return pixel_t'({{6{r[25]}}, r[25:16]});
		endcase
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	////////////////////////////////////////////////////////////////////////////
	// driver with one kernel step per cycle
	////////////////////////////////////////////////////////////////////////////

	task automatic run_conv(input int k);
		int        u;
		int        v;
		feat_vec_t f;
		exp_q.push_back(ref_conv(k));
		for (int s = 0; s < k * k; s++)
		begin
			u = s / k;
			v = s % k;
			for (int i = 0; i < NUM_LANES; i++)
				f.lane[i] = rand_pixel(0);
			// full load, new bottom row, or one new column per group
			for (int x = 0; x < `CONV_PARA_X; x++)
				for (int y = 0; y < `CONV_PARA_Y; y++)
					if (s == 0)
						f.lane[x*`CONV_PARA_Y+y] = img[x][y];
					else if (v == 0 && x == 0)
						f.lane[y] = img[`CONV_PARA_X-1+u][y];
					else if (v != 0 && y == 0)
						f.lane[x] = img[x+u][`CONV_PARA_Y-1+v];
			@(posedge clk);
			#1;
			start       = (s == 0);
			kernel_size = (s == 0) ? `CONV_KSIZE_W'(k) : '0;
			feat_in     = f;
			weight      = ker[u][v];
			if (s == 0)
				due_q.push_back(cyc + k * k + 1);
		end
		@(posedge clk);
		#1;
		start  = 1'b0;
		weight = '0;
		wait (done);
	endtask

	// busy level, done timing and the captured tile
	always @(negedge clk)
	begin
		if (checking)
		begin
			// busy from the cycle after start through the done cycle
			if (busy !== ((due_q.size() != 0) && !start))
				stop_with_failure("busy is not high exactly while a run is in flight");
			if (pending)
			begin
				if (done)
					stop_with_failure("done stayed high for more than one cycle");
				check_result(result, exp_q.pop_front());
				held    = result;
				pending = 1'b0;
			end
			else if (done)
			begin
				if (due_q.size() == 0)
					stop_with_failure("done pulsed without a start");
				if (cyc != due_q[0])
					stop_with_failure($sformatf("done came at cycle %0d, expected cycle %0d",
						cyc, due_q[0]));
				due_q.delete(0);
				pending = 1'b1;
			end
			else if (result !== held)
				stop_with_failure("result changed between done pulses");
		end
	end

	initial
	begin
		int limit;
		limit = 40 * CLK_PERIOD;
		for (int t = 0; t < NUM_TESTS; t++)
			limit += (test_k[t] * test_k[t] + 4) * CLK_PERIOD;
		#(limit);
		stop_with_failure("timed out waiting for the DUT to finish");
	end

	initial
	begin
		rst         = 1'b0;
		start       = 1'b0;
		kernel_size = '0;
		feat_in     = '0;
		weight      = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
		@(negedge clk);
		if (busy !== 1'b0 || done !== 1'b0)
			stop_with_failure("busy or done is not low after reset");
		check_result(result, '0);
		checking = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			for (int x = 0; x < IMG_H; x++)
				for (int y = 0; y < IMG_W; y++)
					img[x][y] = rand_pixel(test_mode[t]);
			for (int u = 0; u < `CONV_KERNEL_MAX; u++)
				for (int v = 0; v < `CONV_KERNEL_MAX; v++)
					ker[u][v] = rand_pixel(test_mode[t] == 0 ? 0 : 1);
			run_conv(test_k[t]);
		end
		repeat (3) @(negedge clk);
		if (exp_q.size() != 0 || pending)
			stop_with_failure("not every expected tile was checked");
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// File: src.f
+incdir+design
+incdir+dv
design/conv_pkg.sv
design/conv_ctrl.sv
design/conv_window.sv
design/conv_mac.sv
design/conv_mac_array.sv
design/conv_tile_top.sv
dv/conv_tb.sv
